/* source/cn_pkg.sv */
package cn_pkg;

    // all currents, gains, drives, thresholds and counts
    typedef logic [31:0] word_t;

    // button gain scaler, 0 to 7
    typedef logic [2:0] scaler_t;

    // apb address width
    localparam int APB_ADDR_W = 8;

    // synaptic gain is 8.8 fixed point
    localparam int GAIN_FRAC_BITS = 8;

    // register map, byte addresses
    typedef enum logic [7:0] {
        REG_CTRL        = 8'h00,
        REG_SYN_GAIN    = 8'h04,
        REG_EXTRA_DRIVE = 8'h08,
        REG_TICK_DIV    = 8'h0C,
        REG_THRESHOLD   = 8'h10,
        REG_SPIKE_COUNT = 8'h14,
        REG_SCALER      = 8'h18
    } reg_addr_e;

    // unity gain in 8.8
    localparam word_t SYN_GAIN_RST = 32'd256;

    // divider for real-time tick rate
    localparam word_t TICK_DIV_RST = 32'd381;

    // 30 shifted left by 10
    localparam word_t THRESHOLD_RST = 32'd30720;

endpackage

/* source/cn_apb_regs.sv */
`timescale 1ns/1ps

module cn_apb_regs (
    input  logic                          ep50trig,
    input  logic                          reset_global,
    input  logic                          i_psel,
    input  logic                          i_penable,
    input  logic                          i_pwrite,
    input  logic [cn_pkg::APB_ADDR_W-1:0] i_paddr,
    input  cn_pkg::word_t                 i_pwdata,
    input  cn_pkg::word_t                 i_spike_count,
    input  cn_pkg::scaler_t               i_gain_scaler,
    output cn_pkg::word_t                 o_prdata,
    output logic                          o_sim_run,
    output cn_pkg::word_t                 o_tick_div,
    output cn_pkg::word_t                 o_syn_gain,
    output cn_pkg::word_t                 o_extra_drive,
    output cn_pkg::word_t                 o_threshold
);
    import cn_pkg::*;

    reg_addr_e addr;
    logic      wr_en;
    logic      rd_en;
    word_t     rd_data;

    // access phase only, setup cycle does nothing
    assign addr  = reg_addr_e'(i_paddr);
    assign wr_en = i_psel & i_penable & i_pwrite;
    assign rd_en = i_psel & i_penable & ~i_pwrite;

    // writable registers, write lands at end of access cycle
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            o_sim_run     <= 1'b0;
            o_syn_gain    <= SYN_GAIN_RST;
            o_extra_drive <= '0;
            o_tick_div    <= TICK_DIV_RST;
            o_threshold   <= THRESHOLD_RST;
        end else if (wr_en) begin
            // read-only and unmapped addresses fall through
            case (addr)
                REG_CTRL:        o_sim_run     <= i_pwdata[0];
                REG_SYN_GAIN:    o_syn_gain    <= i_pwdata;
                REG_EXTRA_DRIVE: o_extra_drive <= i_pwdata;
                REG_TICK_DIV:    o_tick_div    <= i_pwdata;
                REG_THRESHOLD:   o_threshold   <= i_pwdata;
                default:         ;
            endcase
        end
    end

    // read-back mux
    always_comb begin
        case (addr)
            REG_CTRL:        rd_data = {31'd0, o_sim_run};
            REG_SYN_GAIN:    rd_data = o_syn_gain;
            REG_EXTRA_DRIVE: rd_data = o_extra_drive;
            REG_TICK_DIV:    rd_data = o_tick_div;
            REG_THRESHOLD:   rd_data = o_threshold;
            REG_SPIKE_COUNT: rd_data = i_spike_count;
            // scaler zero-extended to a word
            REG_SCALER:      rd_data = {29'd0, i_gain_scaler};
            default:         rd_data = '0;
        endcase
    end

    // bus stays at zero outside a read access cycle
    assign o_prdata = rd_en ? rd_data : '0;

endmodule

/* source/afferent_input.sv */
`timescale 1ns/1ps

module afferent_input (
    input  logic            ep50trig,
    input  logic            reset_global,
    input  logic            i_spike_ia,
    input  logic            i_spike_ii,
    input  logic            i_gain_button,
    input  logic            i_sim_run,
    input  logic            i_tick,
    output logic            o_pending_ia,
    output logic            o_pending_ii,
    output cn_pkg::scaler_t o_gain_scaler
);
    // pin order in the vectors: 2 button, 1 ii, 0 ia
    logic [2:0] sync_1;
    logic [2:0] sync_2;
    logic [2:0] sync_prev;
    logic       edge_ia;
    logic       edge_ii;
    logic       btn_change;
    logic [3:0] pre_scaler;

    // two-flop synchronizer plus one stage for edge detection
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            sync_1    <= '0;
            sync_2    <= '0;
            sync_prev <= '0;
        end else begin
            sync_1    <= {i_gain_button, i_spike_ii, i_spike_ia};
            sync_2    <= sync_1;
            sync_prev <= sync_2;
        end
    end

    assign edge_ia    = sync_2[0] & ~sync_prev[0];
    assign edge_ii    = sync_2[1] & ~sync_prev[1];
    // button counts both level changes
    assign btn_change = sync_2[2] ^ sync_prev[2];

    // pending flags held until the tick consumes them
    // an edge landing in the tick cycle is kept for the next tick
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            o_pending_ia <= 1'b0;
            o_pending_ii <= 1'b0;
        end else if (!i_sim_run) begin
            o_pending_ia <= 1'b0;
            o_pending_ii <= 1'b0;
        end else if (i_tick) begin
            o_pending_ia <= edge_ia;
            o_pending_ii <= edge_ii;
        end else begin
            o_pending_ia <= o_pending_ia | edge_ia;
            o_pending_ii <= o_pending_ii | edge_ii;
        end
    end

    // pre-scaler runs 0..14 and wraps, survives sim_run low
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            pre_scaler <= '0;
        end else if (btn_change) begin
            if (pre_scaler == 4'd14) begin
                pre_scaler <= '0;
            end else begin
                pre_scaler <= pre_scaler + 4'd1;
            end
        end
    end

    // two button changes per scaler step
    assign o_gain_scaler = pre_scaler[3:1];

endmodule

/* source/sim_tick_gen.sv */
`timescale 1ns/1ps

module sim_tick_gen (
    input  logic          ep50trig,
    input  logic          reset_global,
    input  logic          i_sim_run,
    input  cn_pkg::word_t i_tick_div,
    output logic          o_tick
);
    import cn_pkg::*;

    word_t cnt;

    // counter parked at the reload value while stopped
    // so the first tick comes tick_div + 1 cycles after run
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            cnt    <= '0;
            o_tick <= 1'b0;
        end else if (!i_sim_run) begin
            cnt    <= i_tick_div;
            o_tick <= 1'b0;
        end else begin
            // one-cycle pulse each time the count runs out
            o_tick <= (cnt == '0);
            if (cnt == '0) begin
                cnt <= i_tick_div;
            end else begin
                cnt <= cnt - 32'd1;
            end
        end
    end

endmodule

/* source/synapse_current.sv */
`timescale 1ns/1ps

module synapse_current #(
    parameter cn_pkg::word_t SYN_WEIGHT  = 32'd1024,
    parameter int            DECAY_SHIFT = 3
) (
    input  logic          ep50trig,
    input  logic          reset_global,
    input  logic          i_sim_run,
    input  logic          i_tick,
    input  logic          i_pending,
    output cn_pkg::word_t o_current
);
    import cn_pkg::*;

    word_t decayed;
    word_t next_current;

    // exponential decay by a power-of-two fraction
    assign decayed      = o_current - (o_current >> DECAY_SHIFT);
    // pending flag seen here is the one from before the tick
    assign next_current = i_pending ? decayed + SYN_WEIGHT : decayed;

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            o_current <= '0;
        end else if (!i_sim_run) begin
            o_current <= '0;
        end else if (i_tick) begin
            o_current <= next_current;
        end
    end

endmodule

/* source/drive_mixer.sv */
`timescale 1ns/1ps

module drive_mixer #(
    parameter int SENSORY_SHIFT = 4
) (
    input  logic            ep50trig,
    input  logic            reset_global,
    input  logic            i_sim_run,
    input  logic            i_tick,
    input  cn_pkg::word_t   i_current_ia,
    input  cn_pkg::word_t   i_current_ii,
    input  cn_pkg::word_t   i_syn_gain,
    input  cn_pkg::word_t   i_extra_drive,
    input  cn_pkg::scaler_t i_gain_scaler,
    output cn_pkg::word_t   o_drive
);
    import cn_pkg::*;

    word_t       syn_sum;
    logic [63:0] gain_prod;
    word_t       base;
    word_t       sensory;
    word_t       scaled;
    word_t       drive_next;

    // ia and ii currents combined before gain
    assign syn_sum   = i_current_ia + i_current_ii;
    // full product, then drop the 8.8 fraction
    assign gain_prod = 64'(syn_sum) * 64'(i_syn_gain);
    assign base      = word_t'(gain_prod >> GAIN_FRAC_BITS);

    // fixed sensory gain
    assign sensory = base << SENSORY_SHIFT;
    // button gain adds scaler copies on top of the sensory term
    assign scaled  = sensory * word_t'(i_gain_scaler);

    // 32-bit wraparound on the final sum
    assign drive_next = sensory + scaled + i_extra_drive;

    // latched from the currents as they were before this tick
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            o_drive <= '0;
        end else if (!i_sim_run) begin
            o_drive <= '0;
        end else if (i_tick) begin
            o_drive <= drive_next;
        end
    end

endmodule

/* source/lif_neuron.sv */
`timescale 1ns/1ps

module lif_neuron #(
    parameter int LEAK_SHIFT = 4
) (
    input  logic          ep50trig,
    input  logic          reset_global,
    input  logic          i_sim_run,
    input  logic          i_tick,
    input  cn_pkg::word_t i_drive,
    input  cn_pkg::word_t i_threshold,
    output logic          o_fire
);
    import cn_pkg::*;

    word_t v_mem;
    word_t v_next;
    logic  crossed;

    // leak a fraction of the old value, add the latched drive
    assign v_next  = v_mem - (v_mem >> LEAK_SHIFT) + i_drive;
    assign crossed = (v_next >= i_threshold);

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            v_mem  <= '0;
            o_fire <= 1'b0;
        end else if (!i_sim_run) begin
            v_mem  <= '0;
            o_fire <= 1'b0;
        end else if (i_tick) begin
            // fire and reset the membrane on a threshold crossing
            if (crossed) begin
                v_mem  <= '0;
                o_fire <= 1'b1;
            end else begin
                v_mem  <= v_next;
                o_fire <= 1'b0;
            end
        end else begin
            // pulse lasts only the cycle after the tick
            o_fire <= 1'b0;
        end
    end

endmodule

/* source/spike_monitor.sv */
`timescale 1ns/1ps

module spike_monitor (
    input  logic          ep50trig,
    input  logic          reset_global,
    input  logic          i_sim_run,
    input  logic          i_fire,
    output logic          o_spike_out,
    output cn_pkg::word_t o_spike_count
);
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            o_spike_out   <= 1'b0;
            o_spike_count <= '0;
        end else if (!i_sim_run) begin
            // pin held low and count cleared while stopped
            o_spike_out   <= 1'b0;
            o_spike_count <= '0;
        end else begin
            // pin and count move together, one cycle after fire
            o_spike_out <= i_fire;
            if (i_fire) begin
                o_spike_count <= o_spike_count + 32'd1;
            end
        end
    end

endmodule

/* source/cn_top.sv */
`timescale 1ns/1ps

module cn_top #(
    parameter cn_pkg::word_t SYN_WEIGHT_IA = 32'd1024,
    parameter cn_pkg::word_t SYN_WEIGHT_II = 32'd512,
    parameter int            DECAY_SHIFT   = 3,
    parameter int            SENSORY_SHIFT = 4,
    parameter int            LEAK_SHIFT    = 4
) (
    input  logic                          ep50trig,
    input  logic                          reset_global,
    input  logic                          i_psel,
    input  logic                          i_penable,
    input  logic                          i_pwrite,
    input  logic [cn_pkg::APB_ADDR_W-1:0] i_paddr,
    input  cn_pkg::word_t                 i_pwdata,
    input  logic                          i_spike_ia,
    input  logic                          i_spike_ii,
    input  logic                          i_gain_button,
    output cn_pkg::word_t                 o_prdata,
    output logic                          o_spike_out
);
    import cn_pkg::*;

    // register bank outputs
    logic    sim_run;
    word_t   tick_div;
    word_t   syn_gain;
    word_t   extra_drive;
    word_t   threshold;
    // input side
    logic    pending_ia;
    logic    pending_ii;
    scaler_t gain_scaler;
    logic    tick;
    // processing part
    word_t   current_ia;
    word_t   current_ii;
    word_t   drive;
    logic    fire;
    // output side
    word_t   spike_count;

    cn_apb_regs regs_i (
        .ep50trig(ep50trig), .reset_global(reset_global),
        .i_psel(i_psel), .i_penable(i_penable), .i_pwrite(i_pwrite),
        .i_paddr(i_paddr), .i_pwdata(i_pwdata),
        .i_spike_count(spike_count), .i_gain_scaler(gain_scaler),
        .o_prdata(o_prdata), .o_sim_run(sim_run), .o_tick_div(tick_div),
        .o_syn_gain(syn_gain), .o_extra_drive(extra_drive), .o_threshold(threshold)
    );

    afferent_input aff_i (
        .ep50trig(ep50trig), .reset_global(reset_global),
        .i_spike_ia(i_spike_ia), .i_spike_ii(i_spike_ii), .i_gain_button(i_gain_button),
        .i_sim_run(sim_run), .i_tick(tick),
        .o_pending_ia(pending_ia), .o_pending_ii(pending_ii), .o_gain_scaler(gain_scaler)
    );

    sim_tick_gen tick_i (
        .ep50trig(ep50trig), .reset_global(reset_global),
        .i_sim_run(sim_run), .i_tick_div(tick_div), .o_tick(tick)
    );

    // primary (ia) afferent synapse
    synapse_current #(.SYN_WEIGHT(SYN_WEIGHT_IA), .DECAY_SHIFT(DECAY_SHIFT)) syn_ia_i (
        .ep50trig(ep50trig), .reset_global(reset_global), .i_sim_run(sim_run),
        .i_tick(tick), .i_pending(pending_ia), .o_current(current_ia)
    );

    // secondary (ii) afferent synapse, half weight
    synapse_current #(.SYN_WEIGHT(SYN_WEIGHT_II), .DECAY_SHIFT(DECAY_SHIFT)) syn_ii_i (
        .ep50trig(ep50trig), .reset_global(reset_global), .i_sim_run(sim_run),
        .i_tick(tick), .i_pending(pending_ii), .o_current(current_ii)
    );

    drive_mixer #(.SENSORY_SHIFT(SENSORY_SHIFT)) mixer_i (
        .ep50trig(ep50trig), .reset_global(reset_global), .i_sim_run(sim_run),
        .i_tick(tick), .i_current_ia(current_ia), .i_current_ii(current_ii),
        .i_syn_gain(syn_gain), .i_extra_drive(extra_drive),
        .i_gain_scaler(gain_scaler), .o_drive(drive)
    );

    lif_neuron #(.LEAK_SHIFT(LEAK_SHIFT)) neuron_i (
        .ep50trig(ep50trig), .reset_global(reset_global), .i_sim_run(sim_run),
        .i_tick(tick), .i_drive(drive), .i_threshold(threshold), .o_fire(fire)
    );

    spike_monitor mon_i (
        .ep50trig(ep50trig), .reset_global(reset_global), .i_sim_run(sim_run),
        .i_fire(fire), .o_spike_out(o_spike_out), .o_spike_count(spike_count)
    );

endmodule

/* sim/cn_asserts.sv */
`timescale 1ns/1ps

module cn_asserts (
    input logic          ep50trig,
    input logic          reset_global,
    input logic          i_sim_run,
    input logic          i_psel,
    input logic          i_penable,
    input logic          i_pwrite,
    input cn_pkg::word_t i_prdata,
    input logic          i_spike_out
);
    // output pulse is a single cycle
    a_single_pulse: assert property (@(posedge ep50trig) disable iff (reset_global)
        i_spike_out |=> !i_spike_out)
        else $error("o_spike_out high for two cycles in a row");

    // one cycle of grace for a fire already registered when run drops
    a_quiet_stopped: assert property (@(posedge ep50trig) disable iff (reset_global)
        (!i_sim_run && !$past(i_sim_run)) |-> !i_spike_out)
        else $error("o_spike_out high while sim_run is low");

    // read data only in a read access cycle
    a_prdata_idle: assert property (@(posedge ep50trig) disable iff (reset_global)
        !(i_psel && i_penable && !i_pwrite) |-> (i_prdata == '0))
        else $error("o_prdata nonzero outside a read access cycle");

endmodule

bind cn_top cn_asserts asserts_i (
    .ep50trig(ep50trig), .reset_global(reset_global), .i_sim_run(sim_run),
    .i_psel(i_psel), .i_penable(i_penable), .i_pwrite(i_pwrite),
    .i_prdata(o_prdata), .i_spike_out(o_spike_out)
);

/* sim/cn_tb.sv */
`timescale 1ns/1ps

module cn_tb;
    import cn_pkg::*;

    // tick dividers for the pulse spacing test and the random run
    localparam int TEST_DIV = 5;
    localparam int RAND_DIV = 23;
    localparam int RAND_TICKS = 40;

    logic                  ep50trig;
    logic                  reset_global;
    logic                  i_psel;
    logic                  i_penable;
    logic                  i_pwrite;
    logic [APB_ADDR_W-1:0] i_paddr;
    word_t                 i_pwdata;
    logic                  i_spike_ia;
    logic                  i_spike_ii;
    logic                  i_gain_button;
    word_t                 o_prdata;
    logic                  o_spike_out;

    int    errors = 0;
    int    timeouts = 0;
    int    seed = 32'h1e95b042;
    int    btn_changes = 0;
    word_t cycle_cnt = '0;
    word_t pulses = '0;

    // reference model state, one step per tick
    word_t m_ia;
    word_t m_ii;
    word_t m_drv;
    word_t m_v;
    word_t m_fires;
    word_t m_gain;
    word_t m_extra;
    word_t m_thr;
    word_t m_scaler;

    cn_top dut_i (
        .ep50trig(ep50trig), .reset_global(reset_global),
        .i_psel(i_psel), .i_penable(i_penable), .i_pwrite(i_pwrite),
        .i_paddr(i_paddr), .i_pwdata(i_pwdata),
        .i_spike_ia(i_spike_ia), .i_spike_ii(i_spike_ii), .i_gain_button(i_gain_button),
        .o_prdata(o_prdata), .o_spike_out(o_spike_out)
    );

    // 8 ns period
    always #4 ep50trig = ~ep50trig;

    always @(posedge ep50trig) begin
        cycle_cnt <= cycle_cnt + 32'd1;
    end

    // a pulse is one cycle wide so each high sample counts once
    always @(negedge ep50trig) begin
        if (o_spike_out) begin
            pulses <= pulses + 32'd1;
        end
    end

    task automatic check_value(input string name, input word_t got, input word_t exp);
        assert (got == exp) else begin
            $display("CHECK FAILED at %0d ns: %s = %0d, expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic apb_write(input logic [APB_ADDR_W-1:0] addr, input word_t data);
        @(posedge ep50trig);
        #1;
        i_psel    = 1'b1;
        i_penable = 1'b0;
        i_pwrite  = 1'b1;
        i_paddr   = addr;
        i_pwdata  = data;
        @(posedge ep50trig);
        #1;
        i_penable = 1'b1;
        #2;
        // read bus idles at zero during a write
        check_value("o_prdata", o_prdata, 32'd0);
        @(posedge ep50trig);
        #1;
        i_psel    = 1'b0;
        i_penable = 1'b0;
    endtask

    task automatic apb_read(input logic [APB_ADDR_W-1:0] addr, input word_t exp,
                            input string name);
        word_t got;
        @(posedge ep50trig);
        #1;
        i_psel    = 1'b1;
        i_penable = 1'b0;
        i_pwrite  = 1'b0;
        i_paddr   = addr;
        @(posedge ep50trig);
        #1;
        i_penable = 1'b1;
        // sampled mid access cycle
        #2;
        got = o_prdata;
        @(posedge ep50trig);
        #1;
        i_psel    = 1'b0;
        i_penable = 1'b0;
        check_value(name, got, exp);
    endtask

    task automatic read_all(input word_t ctrl, input word_t gain, input word_t extra,
                            input word_t div, input word_t thr);
        apb_read(REG_CTRL, ctrl, "ctrl");
        apb_read(REG_SYN_GAIN, gain, "syn_gain");
        apb_read(REG_EXTRA_DRIVE, extra, "extra_drive");
        apb_read(REG_TICK_DIV, div, "tick_div");
        apb_read(REG_THRESHOLD, thr, "threshold");
    endtask

    task automatic check_spike_low(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge ep50trig);
            check_value("o_spike_out", {31'd0, o_spike_out}, 32'd0);
        end
    endtask

    // step past the pulse once found so the next call sees a new one
    task automatic wait_spike(input int limit, output word_t at_cycle);
        int n;
        n = 0;
        at_cycle = '0;
        @(negedge ep50trig);
        while (!o_spike_out && n < limit) begin
            @(negedge ep50trig);
            n++;
        end
        if (o_spike_out) begin
            at_cycle = cycle_cnt;
            @(negedge ep50trig);
        end else begin
            $display("timeout: no pulse on o_spike_out within %0d cycles", limit);
            timeouts++;
        end
    endtask

    task automatic toggle_button(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge ep50trig);
            #1;
            i_gain_button = ~i_gain_button;
            // hold well past the synchronizer
            repeat (5) @(posedge ep50trig);
        end
        btn_changes += n;
        apb_read(REG_SCALER, word_t'((btn_changes % 15) / 2), "scaler");
    endtask

    // synapse decay 1/8, mixer 8.8 gain then x16 and button copies, leak 1/16
    task automatic model_tick(input logic p_ia, input logic p_ii);
        word_t       n_ia;
        word_t       n_ii;
        word_t       n_drv;
        word_t       v_next;
        word_t       base;
        word_t       sens;
        logic [63:0] prod;
        n_ia   = m_ia - (m_ia >> 3) + (p_ia ? 32'd1024 : 32'd0);
        n_ii   = m_ii - (m_ii >> 3) + (p_ii ? 32'd512 : 32'd0);
        prod   = 64'(m_ia + m_ii) * 64'(m_gain);
        base   = word_t'(prod >> 8);
        sens   = base << 4;
        n_drv  = sens + sens * m_scaler + m_extra;
        v_next = m_v - (m_v >> 4) + m_drv;
        if (v_next >= m_thr) begin
            m_v = '0;
            m_fires = m_fires + 32'd1;
        end else begin
            m_v = v_next;
        end
        m_ia  = n_ia;
        m_ii  = n_ii;
        m_drv = n_drv;
    endtask

    task automatic run_pulse_spacing();
        word_t t_prev;
        word_t t_now;
        word_t start;
        apb_write(REG_TICK_DIV, TEST_DIV);
        apb_write(REG_THRESHOLD, 32'd1);
        apb_write(REG_EXTRA_DRIVE, 32'd1);
        start = pulses;
        apb_write(REG_CTRL, 32'd1);
        wait_spike(4 * (TEST_DIV + 1) + 10, t_prev);
        for (int i = 0; i < 4; i++) begin
            wait_spike(2 * (TEST_DIV + 1), t_now);
            check_value("spike spacing", t_now - t_prev, word_t'(TEST_DIV + 1));
            t_prev = t_now;
        end
        // unreachable threshold stops firing before the counts are compared
        apb_write(REG_THRESHOLD, 32'hFFFF_FFFF);
        repeat (3 * (TEST_DIV + 1)) @(posedge ep50trig);
        apb_read(REG_SPIKE_COUNT, pulses - start, "spike_count");
    endtask

    task automatic run_random_spikes();
        logic [31:0] r;
        logic        spk_ia;
        logic        spk_ii;
        int          pos_ia;
        int          pos_ii;
        m_gain   = 32'd384;
        m_extra  = '0;
        m_thr    = 32'd60000;
        m_scaler = word_t'((btn_changes % 15) / 2);
        m_ia     = '0;
        m_ii     = '0;
        m_drv    = '0;
        m_v      = '0;
        m_fires  = '0;
        apb_write(REG_TICK_DIV, RAND_DIV);
        apb_write(REG_SYN_GAIN, m_gain);
        apb_write(REG_EXTRA_DRIVE, m_extra);
        apb_write(REG_THRESHOLD, m_thr);
        apb_write(REG_CTRL, 32'd1);
        // first tick lands tick_div + 2 edges after the write edge
        repeat (RAND_DIV + 2) @(posedge ep50trig);
        #1;
        model_tick(1'b0, 1'b0);
        for (int k = 0; k < RAND_TICKS; k++) begin
            r      = $random(seed);
            spk_ia = r[0];
            spk_ii = r[1];
            // rise 2 to 14 cycles after the tick and stay high for 2
            pos_ia = 2 + int'(r[11:8]) % 13;
            pos_ii = 2 + int'(r[19:16]) % 13;
            for (int c = 1; c <= RAND_DIV + 1; c++) begin
                @(posedge ep50trig);
                #1;
                i_spike_ia = spk_ia && (c >= pos_ia) && (c < pos_ia + 2);
                i_spike_ii = spk_ii && (c >= pos_ii) && (c < pos_ii + 2);
            end
            model_tick(spk_ia, spk_ii);
        end
        // last fire reaches the count 1 edge after its tick
        repeat (3) @(posedge ep50trig);
        apb_read(REG_SPIKE_COUNT, m_fires, "spike_count");
    endtask

    initial begin
        ep50trig      = 1'b0;
        reset_global  = 1'b1;
        i_psel        = 1'b0;
        i_penable     = 1'b0;
        i_pwrite      = 1'b0;
        i_paddr       = '0;
        i_pwdata      = '0;
        i_spike_ia    = 1'b0;
        i_spike_ii    = 1'b0;
        i_gain_button = 1'b0;
        repeat (5) @(posedge ep50trig);
        #1;
        reset_global = 1'b0;

        // reset values, unity gain and 30 shifted left by 10
        read_all(32'd0, 32'd256, 32'd0, 32'd381, 32'd30720);
        apb_read(REG_SPIKE_COUNT, 32'd0, "spike_count");
        apb_read(REG_SCALER, 32'd0, "scaler");
        check_spike_low(20);

        // write and read back
        // ctrl keeps only bit 0
        apb_write(REG_CTRL, 32'hFFFF_FFFF);
        apb_write(REG_SYN_GAIN, 32'h0000_0123);
        apb_write(REG_EXTRA_DRIVE, 32'hA5A5_0F0F);
        apb_write(REG_TICK_DIV, 32'd777);
        apb_write(REG_THRESHOLD, 32'h0012_3456);
        read_all(32'd1, 32'h0000_0123, 32'hA5A5_0F0F, 32'd777, 32'h0012_3456);
        apb_write(REG_CTRL, 32'd0);
        // read-only and unmapped writes are dropped
        apb_write(REG_SPIKE_COUNT, 32'h55);
        apb_write(8'h1C, 32'hAA);
        apb_read(REG_SPIKE_COUNT, 32'd0, "spike_count");
        apb_read(8'h1C, 32'd0, "unmapped");
        read_all(32'd0, 32'h0000_0123, 32'hA5A5_0F0F, 32'd777, 32'h0012_3456);

        // button pre-scaler wraps at 15
        toggle_button(3);
        toggle_button(8);
        toggle_button(6);

        run_pulse_spacing();

        // a stopped neuron that would fire every tick if running
        apb_write(REG_CTRL, 32'd0);
        apb_read(REG_SPIKE_COUNT, 32'd0, "spike_count");
        apb_write(REG_THRESHOLD, 32'd1);
        check_spike_low(3 * (TEST_DIV + 1));
        apb_read(REG_SPIKE_COUNT, 32'd0, "spike_count");

        run_random_spikes();
        apb_write(REG_CTRL, 32'd0);

        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* verilog.f */
source/cn_pkg.sv
source/cn_apb_regs.sv
source/afferent_input.sv
source/sim_tick_gen.sv
source/synapse_current.sv
source/drive_mixer.sv
source/lif_neuron.sv
source/spike_monitor.sv
source/cn_top.sv
sim/cn_asserts.sv
sim/cn_tb.sv

/* Makefile */
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build cn_tb with Verilator, run it and check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Mdir obj_dir --top-module cn_tb -f verilog.f
	./obj_dir/Vcn_tb 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "TEST PASSED" $(LOG); then echo "simulation ended without passing"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
